// File: common/jerry_pkg.sv
// Shared widths, register map, enums and structs
// for the Jerry host timer and interrupt core
package jerry_pkg;

	// Bus and register widths
	localparam int IO_ADDR_W = 16;
	localparam int DATA_W    = 16;

	// Two interval timers
	localparam int NUM_PIT   = 2;

	// Interrupt sources and their bit positions
	localparam int INT_SRC_W = 3;
	localparam int INT_EXT   = 0;
	localparam int INT_TIM0  = 1;
	localparam int INT_TIM1  = 2;

	typedef logic [IO_ADDR_W-1:0] io_addr_t;
	typedef logic [DATA_W-1:0]    io_data_t;

	// Timer reload registers, two per timer
	localparam io_addr_t PIT1_OFS  = 16'h0000;
	localparam io_addr_t PIT2_OFS  = 16'h0002;
	localparam io_addr_t PIT3_OFS  = 16'h0004;
	localparam io_addr_t PIT4_OFS  = 16'h0006;
	// Enables, pending clear and status
	localparam io_addr_t INT_OFS   = 16'h0020;
	// Live counter readback, read only
	localparam io_addr_t PIT1R_OFS = 16'h0036;
	localparam io_addr_t PIT2R_OFS = 16'h0038;
	localparam io_addr_t PIT3R_OFS = 16'h003A;
	localparam io_addr_t PIT4R_OFS = 16'h003C;

	// Host access sequencer
	typedef enum logic [1:0] {
		IDLE,
		WRITE,
		READ,
		HOLD
	} host_state_e;

	// Decoded register select
	typedef enum logic [3:0] {
		REG_NONE,
		REG_PIT1,
		REG_PIT2,
		REG_PIT3,
		REG_PIT4,
		REG_INT,
		REG_PIT1R,
		REG_PIT2R,
		REG_PIT3R,
		REG_PIT4R
	} io_reg_e;

	// One access from the sequencer, pulses last a single cycle
	typedef struct packed {
		logic     wr;
		logic     rd;
		io_addr_t addr;
		io_data_t data;
	} host_req_t;

	// Per timer register write strobes
	typedef struct packed {
		logic pre_wr;
		logic div_wr;
	} pit_cfg_wr_t;

	// Prescaler and divider words of one timer
	typedef struct packed {
		io_data_t pre;
		io_data_t div;
	} pit_count_t;

endpackage

// File: logic/host_access_fsm.sv
// Host bus slave sequencer
// Turns held select and strobe levels into one register access per host cycle
module host_access_fsm (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 dspcsl,
	input  logic                 wel,
	input  logic                 oel,
	input  jerry_pkg::io_addr_t  a,
	input  jerry_pkg::io_data_t  din,
	output jerry_pkg::host_req_t req,
	output logic                 den
);
	import jerry_pkg::*;

	host_state_e state;
	host_state_e state_nxt;
	io_addr_t    addr_q;
	io_data_t    data_q;
	logic        wr_req;
	logic        rd_req;

	// Write wins if the host drives both strobes
	assign wr_req = !dspcsl && !wel;
	assign rd_req = !dspcsl && !oel && wel;

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: begin
				if (wr_req) begin
					state_nxt = WRITE;
				end else if (rd_req) begin
					state_nxt = READ;
				end
			end
			// Access done in one cycle and then wait for release
			WRITE, READ: state_nxt = HOLD;
			HOLD: begin
				if (dspcsl) begin
					state_nxt = IDLE;
				end
			end
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// Address and data sampled while idle as the host keeps them stable
	always_ff @(posedge clk) begin
		if (state == IDLE) begin
			addr_q <= a;
			data_q <= din;
		end
	end

	// Data bus drive from the read cycle until select goes away
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			den <= 1'b0;
		end else if (state == READ) begin
			den <= 1'b1;
		end else if (state == HOLD && dspcsl) begin
			den <= 1'b0;
		end
	end

	always_comb begin
		req.wr   = (state == WRITE);
		req.rd   = (state == READ);
		req.addr = addr_q;
		req.data = data_q;
	end

	// Never both pulses in one cycle
	a_pulse_excl: assert property (@(posedge clk) disable iff (!rst_n)
		!(req.wr && req.rd));

endmodule

// File: logic/io_decode.sv
// Jerry I/O decoder
// Address to register select, write strobes and registered read data
module io_decode (
	input  logic                                            clk,
	input  logic                                            rst_n,
	input  jerry_pkg::host_req_t                            req,
	input  jerry_pkg::pit_count_t  [jerry_pkg::NUM_PIT-1:0] pit_count,
	input  jerry_pkg::pit_count_t  [jerry_pkg::NUM_PIT-1:0] pit_reload,
	input  jerry_pkg::io_data_t                             int_status,
	output jerry_pkg::pit_cfg_wr_t [jerry_pkg::NUM_PIT-1:0] pit_wr,
	output logic                                            int_wr,
	output jerry_pkg::io_data_t                             wdata,
	output jerry_pkg::io_data_t                             dout
);
	import jerry_pkg::*;

	io_reg_e  reg_sel;
	io_data_t rdata;

	// Full address compare, anything else is unmapped
	always_comb begin
		case (req.addr)
			PIT1_OFS:  reg_sel = REG_PIT1;
			PIT2_OFS:  reg_sel = REG_PIT2;
			PIT3_OFS:  reg_sel = REG_PIT3;
			PIT4_OFS:  reg_sel = REG_PIT4;
			INT_OFS:   reg_sel = REG_INT;
			PIT1R_OFS: reg_sel = REG_PIT1R;
			PIT2R_OFS: reg_sel = REG_PIT2R;
			PIT3R_OFS: reg_sel = REG_PIT3R;
			PIT4R_OFS: reg_sel = REG_PIT4R;
			default:   reg_sel = REG_NONE;
		endcase
	end

	// Strobes follow the write pulse only
	// Counter readback registers ignore writes
	always_comb begin
		pit_wr = '0;
		int_wr = 1'b0;
		if (req.wr) begin
			case (reg_sel)
				REG_PIT1: pit_wr[0].pre_wr = 1'b1;
				REG_PIT2: pit_wr[0].div_wr = 1'b1;
				REG_PIT3: pit_wr[1].pre_wr = 1'b1;
				REG_PIT4: pit_wr[1].div_wr = 1'b1;
				REG_INT:  int_wr = 1'b1;
				default:  ;
			endcase
		end
	end

	assign wdata = req.data;

	// Read mux, zero for unmapped
	always_comb begin
		case (reg_sel)
			REG_PIT1:  rdata = pit_reload[0].pre;
			REG_PIT2:  rdata = pit_reload[0].div;
			REG_PIT3:  rdata = pit_reload[1].pre;
			REG_PIT4:  rdata = pit_reload[1].div;
			REG_INT:   rdata = int_status;
			REG_PIT1R: rdata = pit_count[0].pre;
			REG_PIT2R: rdata = pit_count[0].div;
			REG_PIT3R: rdata = pit_count[1].pre;
			REG_PIT4R: rdata = pit_count[1].div;
			default:   rdata = '0;
		endcase
	end

	// Sampled on the read pulse, held while den is up
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dout <= '0;
		end else if (req.rd) begin
			dout <= rdata;
		end
	end

	a_one_wr: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0({pit_wr, int_wr}));

endmodule

// File: timer/pit_timer.sv
// Programmable interval timer
// Prescaler and divider down-counters give a tick every (P+1)*(D+1) clocks
module pit_timer (
	input  logic                   clk,
	input  logic                   rst_n,
	input  jerry_pkg::pit_cfg_wr_t wr,
	input  jerry_pkg::io_data_t    wdata,
	output jerry_pkg::pit_count_t  count,
	output jerry_pkg::pit_count_t  reload,
	output logic                   tick
);
	import jerry_pkg::*;

	io_data_t pre_rld;
	io_data_t div_rld;
	io_data_t pre_cnt;
	io_data_t div_cnt;
	logic     cfg_wr;
	logic     running;
	logic     pre_zero;

	assign cfg_wr   = wr.pre_wr | wr.div_wr;
	// Zero divider stops the timer
	assign running  = (div_rld != '0);
	assign pre_zero = (pre_cnt == '0);

	// Both counts at zero ends the period
	// A register write restarts instead
	assign tick = running && !cfg_wr && pre_zero && (div_cnt == '0);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pre_rld <= '0;
			div_rld <= '0;
		end else begin
			if (wr.pre_wr) begin
				pre_rld <= wdata;
			end
			if (wr.div_wr) begin
				div_rld <= wdata;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pre_cnt <= '0;
			div_cnt <= '0;
		end else if (cfg_wr) begin
			// Either write reloads both, new value goes straight in
			pre_cnt <= wr.pre_wr ? wdata : pre_rld;
			div_cnt <= wr.div_wr ? wdata : div_rld;
		end else if (running) begin
			if (pre_zero) begin
				pre_cnt <= pre_rld;
				if (tick) begin
					div_cnt <= div_rld;
				end else begin
					div_cnt <= div_cnt - 1'b1;
				end
			end else begin
				pre_cnt <= pre_cnt - 1'b1;
			end
		end
	end

	assign count.pre  = pre_cnt;
	assign count.div  = div_cnt;
	assign reload.pre = pre_rld;
	assign reload.div = div_rld;

	// Divider reload is nonzero while running, so no back to back ticks
	a_tick_single: assert property (@(posedge clk) disable iff (!rst_n)
		tick |=> !tick);

endmodule

// File: logic/int_ctrl.sv
// Interrupt controller
// Latches enabled timer and external events and drives the CPU interrupt
module int_ctrl (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          int_wr,
	input  jerry_pkg::io_data_t           wdata,
	input  logic [jerry_pkg::NUM_PIT-1:0] tim_tick,
	input  logic                          eint_n,
	output jerry_pkg::io_data_t           status,
	output logic                          xint
);
	import jerry_pkg::*;

	logic [INT_SRC_W-1:0] int_en;
	logic [INT_SRC_W-1:0] int_pend;
	logic [INT_SRC_W-1:0] int_evt;
	logic [INT_SRC_W-1:0] int_clr;
	logic [2:0]           eint_sync;
	logic                 eint_fall;

	// Two sync flops and a third one for the edge
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			eint_sync <= '1;
		end else begin
			eint_sync <= {eint_sync[1:0], eint_n};
		end
	end

	assign eint_fall = eint_sync[2] & ~eint_sync[1];

	always_comb begin
		int_evt           = '0;
		int_evt[INT_EXT]  = eint_fall;
		int_evt[INT_TIM0] = tim_tick[0];
		int_evt[INT_TIM1] = tim_tick[1];
	end

	// Clear mask in bits 10:8
	assign int_clr = int_wr ? wdata[8 +: INT_SRC_W] : '0;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			int_en   <= '0;
			int_pend <= '0;
		end else begin
			if (int_wr) begin
				int_en <= wdata[0 +: INT_SRC_W];
			end
			// set over clear
			int_pend <= (int_pend & ~int_clr) | (int_evt & int_en);
		end
	end

	// Pending in 2:0 and enables in 6:4
	always_comb begin
		status                = '0;
		status[0 +: INT_SRC_W] = int_pend;
		status[4 +: INT_SRC_W] = int_en;
	end

	assign xint = |(int_pend & int_en);

endmodule

// File: logic/jerry_io.sv
// Jerry host timer and interrupt core
// Host sequencer, decoder, two interval timers and interrupt controller
module jerry_io (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                dspcsl,
	input  logic                wel,
	input  logic                oel,
	input  jerry_pkg::io_addr_t a,
	input  jerry_pkg::io_data_t din,
	input  logic                eint_n,
	output jerry_pkg::io_data_t dout,
	output logic                den,
	output logic                xint
);
	import jerry_pkg::*;

	host_req_t                 host_req;
	pit_cfg_wr_t [NUM_PIT-1:0] pit_wr;
	pit_count_t  [NUM_PIT-1:0] pit_count;
	pit_count_t  [NUM_PIT-1:0] pit_reload;
	logic        [NUM_PIT-1:0] pit_tick;
	logic                      int_wr;
	io_data_t                  wdata;
	io_data_t                  int_status;

	// Host slave port
	host_access_fsm u_host (
		.clk    (clk),
		.rst_n  (rst_n),
		.dspcsl (dspcsl),
		.wel    (wel),
		.oel    (oel),
		.a      (a),
		.din    (din),
		.req    (host_req),
		.den    (den)
	);

	io_decode u_dec (
		.clk        (clk),
		.rst_n      (rst_n),
		.req        (host_req),
		.pit_count  (pit_count),
		.pit_reload (pit_reload),
		.int_status (int_status),
		.pit_wr     (pit_wr),
		.int_wr     (int_wr),
		.wdata      (wdata),
		.dout       (dout)
	);

	// One timer per prescaler/divider pair
	generate
		for (genvar i = 0; i < NUM_PIT; i++) begin : g_pit
			pit_timer u_pit (
				.clk    (clk),
				.rst_n  (rst_n),
				.wr     (pit_wr[i]),
				.wdata  (wdata),
				.count  (pit_count[i]),
				.reload (pit_reload[i]),
				.tick   (pit_tick[i])
			);
		end
	endgenerate

	int_ctrl u_int (
		.clk      (clk),
		.rst_n    (rst_n),
		.int_wr   (int_wr),
		.wdata    (wdata),
		.tim_tick (pit_tick),
		.eint_n   (eint_n),
		.status   (int_status),
		.xint     (xint)
	);

endmodule

// File: dv/tb_clkgen.sv
// Testbench clock and reset source
// 100 ns clock, reset held low for the first 8 cycles
module tb_clkgen (
	output logic clk,
	output logic rst_n
);
	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Release away from the rising edge
	initial begin
		rst_n = 1'b0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	end

endmodule

// File: dv/jerry_io_tb.sv
// Directed testbench for the Jerry timer and interrupt core
// Host accesses, timer periods, interrupt masking and unmapped addresses
module jerry_io_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import jerry_pkg::*;

	logic     clk;
	logic     rst_n;
	logic     dspcsl;
	logic     wel;
	logic     oel;
	io_addr_t a;
	io_data_t din;
	logic     eint_n;
	io_data_t dout;
	logic     den;
	logic     xint;

	int errors = 0;
	int tests = 0;
	int failed_tests = 0;
	int cyc = 0;
	// Prescaler values left in each timer, dividers end at zero
	int pre_val[NUM_PIT];

	tb_clkgen u_clk (
		.clk   (clk),
		.rst_n (rst_n)
	);

	jerry_io uut (
		.clk    (clk),
		.rst_n  (rst_n),
		.dspcsl (dspcsl),
		.wel    (wel),
		.oel    (oel),
		.a      (a),
		.din    (din),
		.eint_n (eint_n),
		.dout   (dout),
		.den    (den),
		.xint   (xint)
	);

	// Cycle count, read on falling edges only
	always @(posedge clk) cyc <= cyc + 1;

	task automatic report_mismatch(input string sig, input logic [31:0] exp,
		input logic [31:0] act);
		$display("ERR %0t %s expected %0h actual %0h", $time, sig, exp, act);
		errors++;
	endtask

	task automatic report_failure(input string msg);
		$display("%0t %s", $time, msg);
		errors++;
	endtask

	task automatic end_test(input string name, input int err_before);
		tests++;
		if (errors == err_before) begin
			$display("test %s: pass", name);
		end else begin
			$display("test %s: fail, %0d errors", name, errors - err_before);
			failed_tests++;
		end
	endtask

	// Called and returns on a falling edge with the sequencer idle
	// Write lands at the second rising edge, third edge sees select high
	task automatic host_write(input io_addr_t addr, input io_data_t data);
		dspcsl = 1'b0;
		wel    = 1'b0;
		oel    = 1'b1;
		a      = addr;
		din    = data;
		@(negedge clk);
		if (den !== 1'b0) report_mismatch("den", 0, den);
		@(negedge clk);
		dspcsl = 1'b1;
		wel    = 1'b1;
		@(negedge clk);
		if (den !== 1'b0) report_mismatch("den", 0, den);
	endtask

	task automatic host_read(input io_addr_t addr, output io_data_t data);
		int n;
		if (den !== 1'b0) report_mismatch("den", 0, den);
		dspcsl = 1'b0;
		oel    = 1'b0;
		wel    = 1'b1;
		a      = addr;
		n = 0;
		while (den !== 1'b1 && n < 8) begin
			@(negedge clk);
			n++;
		end
		if (den !== 1'b1) report_failure("den did not rise during a read");
		data = dout;
		dspcsl = 1'b1;
		oel    = 1'b1;
		// den drops on the edge that sees select released
		n = 0;
		while (den !== 1'b0 && n < 8) begin
			@(negedge clk);
			n++;
		end
		if (den !== 1'b0) report_failure("den stayed high after select was released");
	endtask

	// Two xint rises around a clear write, spaced by one timer period
	task automatic measure_period(input int exp, input io_data_t clr, input string name);
		int n;
		int t0;
		n = 0;
		while (xint !== 1'b1 && n < exp + 20) begin
			@(negedge clk);
			n++;
		end
		if (xint !== 1'b1) begin
			report_failure({name, " never raised xint"});
		end else begin
			t0 = cyc;
			host_write(INT_OFS, clr);
			if (xint !== 1'b0) report_mismatch("xint", 0, xint);
			n = 0;
			while (xint !== 1'b1 && n < exp + 20) begin
				@(negedge clk);
				n++;
			end
			if (xint !== 1'b1) begin
				report_failure({name, " did not raise xint again after the clear"});
			end else if (cyc - t0 != exp) begin
				report_mismatch("xint period", exp, cyc - t0);
			end
		end
	endtask

	task automatic test_reset();
		int       e0;
		io_data_t v;
		e0 = errors;
		if (xint !== 1'b0) report_mismatch("xint", 0, xint);
		if (den !== 1'b0) report_mismatch("den", 0, den);
		host_read(INT_OFS, v);
		if (v !== 16'h0000) report_mismatch("dout", 0, v);
		end_test("reset state", e0);
	endtask

	task automatic test_regs();
		int       e0;
		int       i;
		io_data_t en;
		io_data_t v;
		io_addr_t ofs[4];
		io_data_t rld[4];
		e0 = errors;
		ofs = '{PIT1_OFS, PIT2_OFS, PIT3_OFS, PIT4_OFS};
		en = io_data_t'($urandom % 8);
		host_write(INT_OFS, en);
		host_read(INT_OFS, v);
		if ((v & 16'h0070) !== (en << 4)) report_mismatch("dout[6:4]", en, v[6:4]);
		// Mask everything before the timers start
		host_write(INT_OFS, 16'h0700);
		for (i = 0; i < 4; i++) begin
			rld[i] = io_data_t'($urandom);
			host_write(ofs[i], rld[i]);
		end
		for (i = 0; i < 4; i++) begin
			host_read(ofs[i], v);
			if (v !== rld[i]) report_mismatch("dout", rld[i], v);
		end
		host_write(PIT2_OFS, 16'h0000);
		host_write(PIT4_OFS, 16'h0000);
		pre_val[0] = int'(rld[0]);
		pre_val[1] = int'(rld[2]);
		end_test("register read-back", e0);
	endtask

	task automatic test_timer0();
		int e0;
		int p;
		int d;
		e0 = errors;
		p = 1 + int'($urandom % 7);
		d = 1 + int'($urandom % 7);
		host_write(PIT1_OFS, io_data_t'(p));
		host_write(PIT2_OFS, io_data_t'(d));
		// Clear all pending, enable timer 0 only
		host_write(INT_OFS, 16'h0702);
		measure_period((p + 1) * (d + 1), 16'h0202, "timer 0");
		host_write(PIT2_OFS, 16'h0000);
		host_write(INT_OFS, 16'h0700);
		pre_val[0] = p;
		end_test("timer 0 period", e0);
	endtask

	task automatic test_timer1();
		int       e0;
		int       p;
		int       d;
		int       n;
		logic     seen;
		io_data_t v;
		e0 = errors;
		p = 1 + int'($urandom % 7);
		d = 1 + int'($urandom % 7);
		host_write(PIT3_OFS, io_data_t'(p));
		host_write(PIT4_OFS, io_data_t'(d));
		host_write(INT_OFS, 16'h0704);
		measure_period((p + 1) * (d + 1), 16'h0404, "timer 1");
		// Pending bit 2 and enable bit 6
		host_read(INT_OFS, v);
		if (v !== 16'h0044) report_mismatch("dout", 16'h0044, v);
		// Zero divider stops it, enable stays on
		host_write(PIT4_OFS, 16'h0000);
		host_write(INT_OFS, 16'h0704);
		seen = 1'b0;
		for (n = 0; n < 200; n++) begin
			@(negedge clk);
			if (xint !== 1'b0) seen = 1'b1;
		end
		if (seen) report_failure("xint rose while timer 1 was stopped");
		host_write(INT_OFS, 16'h0700);
		pre_val[1] = p;
		end_test("timer 1 and stop", e0);
	endtask

	task automatic test_ext();
		int   e0;
		int   n;
		logic seen;
		e0 = errors;
		host_write(INT_OFS, 16'h0700);
		eint_n = 1'b0;
		seen = 1'b0;
		for (n = 0; n < 20; n++) begin
			@(negedge clk);
			if (xint !== 1'b0) seen = 1'b1;
		end
		if (seen) report_failure("masked external interrupt raised xint");
		eint_n = 1'b1;
		// Let the synchronizer settle high again
		repeat (5) @(negedge clk);
		host_write(INT_OFS, 16'h0701);
		eint_n = 1'b0;
		n = 0;
		while (xint !== 1'b1 && n < 10) begin
			@(negedge clk);
			n++;
		end
		if (xint !== 1'b1) report_failure("enabled external interrupt never raised xint");
		host_write(INT_OFS, 16'h0101);
		if (xint !== 1'b0) report_mismatch("xint", 0, xint);
		eint_n = 1'b1;
		repeat (5) @(negedge clk);
		host_write(INT_OFS, 16'h0700);
		end_test("external interrupt", e0);
	endtask

	task automatic test_unmapped();
		int       e0;
		int       i;
		io_data_t v;
		io_addr_t maps[9];
		io_data_t exp[9];
		e0 = errors;
		maps = '{PIT1_OFS, PIT2_OFS, PIT3_OFS, PIT4_OFS, INT_OFS,
			PIT1R_OFS, PIT2R_OFS, PIT3R_OFS, PIT4R_OFS};
		// Stopped timers hold prescaler reload and zero divider
		exp = '{io_data_t'(pre_val[0]), 16'h0000, io_data_t'(pre_val[1]), 16'h0000,
			16'h0000, io_data_t'(pre_val[0]), 16'h0000, io_data_t'(pre_val[1]), 16'h0000};
		host_write(16'h0012, io_data_t'($urandom));
		host_read(16'h0012, v);
		if (v !== 16'h0000) report_mismatch("dout", 0, v);
		for (i = 0; i < 9; i++) begin
			host_read(maps[i], v);
			if (v !== exp[i]) report_mismatch("dout", exp[i], v);
		end
		end_test("unmapped access", e0);
	endtask

	initial begin
		int n;
		void'($urandom(82));
		dspcsl = 1'b1;
		wel    = 1'b1;
		oel    = 1'b1;
		a      = '0;
		din    = '0;
		eint_n = 1'b1;
		n = 0;
		while (rst_n !== 1'b1 && n < 20) begin
			@(posedge clk);
			n++;
		end
		if (rst_n !== 1'b1) report_failure("reset was never released");
		@(negedge clk);
		test_reset();
		test_regs();
		test_timer0();
		test_timer1();
		test_ext();
		test_unmapped();
		$display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

// File: files.f
common/jerry_pkg.sv
logic/host_access_fsm.sv
logic/io_decode.sv
timer/pit_timer.sv
logic/int_ctrl.sv
logic/jerry_io.sv
dv/tb_clkgen.sv
dv/jerry_io_tb.sv

// File: Makefile
# Verilator build and run of the Jerry I/O testbench

VERILATOR ?= verilator
TOP       ?= jerry_io_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
PASS_MSG  ?= ALL CHECKS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
